//--- dv/op_patterns.txt
# w lines hold address and data in hex with address bit 2 selecting the envelope page
# e lines hold frame, slot and signed expected value in decimal with frames counted from 0
# slot 0 triangle ar 15 rr 8 and slots 1 and 2 square at multiplier 2 and 4
w 4 0f80
w 0 f800
w 5 8f00
w 1 f401
w 6 8f00
w 2 f403
e 0 0 0
e 0 1 7
e 0 2 7
e 0 3 0
e 1 0 1028
e 1 1 2047
e 1 2 2047
e 2 0 2047
e 2 2 -2047
e 3 0 1019
e 3 1 2047
e 4 1 -2047
e 4 2 2047
e 4 3 0
# slot 0 key off and slot 3 triangle with fb 4
w 0 7800
w 7 4f00
w 3 d800
e 5 0 -65
e 5 3 0
e 6 0 -8
e 6 3 257
e 7 0 -1
e 7 3 1542
e 8 0 0
e 8 1 2047
e 8 3 -224
# slot 0 keyed on again
w 0 f800
e 9 0 0
e 9 3 -1895
# slot 3 gets tl 3
w 7 4f03
e 10 0 1028
e 10 3 124
e 11 0 2047
e 11 2 -2047
e 11 3 181

//--- dv/opl_op_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module opl_op_core_tb;

    localparam int NUM_SLOTS = 4;           // DUT default
    localparam int WAIT_LIMIT = 100;        // cycles allowed for any single wait

    logic clk;
    logic rst;
    logic reg_we;
    logic [2:0] reg_addr;                   // page bit on top, slot below
    logic [15:0] reg_wdata;
    logic out_valid;
    logic [1:0] out_slot;
    logic signed [11:0] out_value;
    logic frame_done;

    integer seed;                           // $random state
    int frame_cnt;                          // frames captured so far
    int n_expect;                           // expect records checked
    logic signed [31:0] got [NUM_SLOTS];    // last frame, indexed by slot

    opl_op_core opl_op_core_i (
        .clk, .rst, .reg_we, .reg_addr, .reg_wdata,
        .out_valid, .out_slot, .out_value, .frame_done
    );

    always #10 clk = ~clk;                  // 20 ns period

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
        if (actual !== expected)
            abort_run($sformatf("FAIL %s expected %0d actual %0d", name, expected, actual));
    endtask

    // one host write, reg_we stays up until the next write or frame wait
    task automatic write_reg(input logic [2:0] addr, input logic [15:0] data);
        int gap;
        gap = $random(seed) & 1;            // 0 or 1 idle cycles
        if (gap != 0) begin
            @(posedge clk);
            reg_we <= 1'b0;
        end
        @(posedge clk);
        reg_we <= 1'b1;
        reg_addr <= addr;
        reg_wdata <= data;
    endtask

    // captures one frame and checks its shape
    task automatic run_frame();
        int waited;
        @(posedge clk);
        reg_we <= 1'b0;                     // last pending write lands here
        waited = 0;
        @(negedge clk);
        while (out_valid !== 1'b1) begin
            check_value($sformatf("frame %0d frame_done while idle", frame_cnt), 0, frame_done);
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run($sformatf("timeout waiting for out_valid of frame %0d", frame_cnt));
            @(negedge clk);
        end
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (i > 0)
                @(negedge clk);             // slots come back to back
            check_value($sformatf("frame %0d out_valid at %0d", frame_cnt, i), 1, out_valid);
            check_value($sformatf("frame %0d out_slot", frame_cnt), i, out_slot);
            check_value($sformatf("frame %0d frame_done at slot %0d", frame_cnt, i),
                        (i == NUM_SLOTS - 1), frame_done);
            got[i] = out_value;             // sign extended
        end
        @(negedge clk);                     // burst is exactly NUM_SLOTS long
        check_value($sformatf("frame %0d out_valid after last slot", frame_cnt), 0, out_valid);
        frame_cnt++;
    endtask

    initial begin
        int fd;
        int code;
        int ch;
        int e_frame;
        int e_slot;
        int e_value;
        logic [2:0] w_addr;
        logic [15:0] w_data;
        logic [7:0] kind;
        clk = 1'b0;
        rst = 1'b1;
        reg_we = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        seed = 32'hc9c4;
        frame_cnt = 0;
        n_expect = 0;
        fd = $fopen("dv/op_patterns.txt", "r");
        if (fd == 0)
            abort_run("cannot open dv/op_patterns.txt");
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        while (!$feof(fd)) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1)
                break;                      // trailing whitespace only
            if (kind == "#") begin
                ch = 0;
                while (ch != 10 && ch != -1)
                    ch = $fgetc(fd);        // drop rest of comment line
            end else if (kind == "w") begin
                code = $fscanf(fd, "%h %h", w_addr, w_data);
                if (code != 2)
                    abort_run("malformed write record in dv/op_patterns.txt");
                write_reg(w_addr, w_data);
            end else if (kind == "e") begin
                code = $fscanf(fd, "%d %d %d", e_frame, e_slot, e_value);
                if (code != 3 || e_slot < 0 || e_slot >= NUM_SLOTS)
                    abort_run("malformed expect record in dv/op_patterns.txt");
                while (frame_cnt <= e_frame)
                    run_frame();
                if (e_frame != frame_cnt - 1)
                    abort_run($sformatf("expect record for frame %0d is out of order", e_frame));
                check_value($sformatf("frame %0d slot %0d out_value", e_frame, e_slot),
                            e_value, got[e_slot]);
                n_expect++;
            end else begin
                abort_run($sformatf("unknown record kind %c in dv/op_patterns.txt", kind));
            end
        end
        $fclose(fd);
        if (n_expect == 0)
            abort_run("no expect records found in dv/op_patterns.txt");
        else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- opl_op_core.f
source/opl_op_pkg.sv
source/sample_timer.sv
source/slot_sequencer.sv
source/slot_regs.sv
source/env_gen.sv
source/fm_operator.sv
source/opl_op_core.sv
dv/opl_op_core_tb.sv

//--- source/env_gen.sv
`timescale 1ns/1ps
`default_nettype none

module env_gen
    import opl_op_pkg::*;
#(
    parameter int NUM_SLOTS = 4,
    localparam int SLOT_W = $clog2(NUM_SLOTS)
) (
    input wire clk,
    input wire rst,
    input wire valid_p1,
    input wire [SLOT_W-1:0] slot_p1,
    input wire key_on_p1,
    input wire key_off_p1,
    input wire [3:0] ar,                    // stage 0, from slot_regs
    input wire [3:0] rr,
    output logic [ENV_WIDTH-1:0] env_level_p2
);
    localparam logic [ENV_WIDTH-1:0] ENV_MAX = {ENV_WIDTH{1'b1}};

    // level kept inverted, so a cleared entry is a silent slot
    logic [ENV_WIDTH-1:0] lvl_inv_mem [NUM_SLOTS];
    logic atk_mem [NUM_SLOTS];              // 1 while attacking

    logic [3:0] ar_p1;
    logic [3:0] rr_p1;
    logic [ENV_WIDTH-1:0] cur_level;
    logic [ENV_WIDTH-1:0] next_level;
    logic [ENV_WIDTH-1:0] atk_step;
    logic [ENV_WIDTH:0] rel_sum;            // one spare bit for the cap
    logic atk_next;

    always_comb begin
        cur_level = key_on_p1 ? ENV_MAX : ~lvl_inv_mem[slot_p1];    // restart from silence
        atk_next = key_on_p1 | (atk_mem[slot_p1] & ~key_off_p1);
        atk_step = {1'b0, ar_p1, 2'b00};    // 4 * ar
        rel_sum = {1'b0, cur_level} + {2'b00, rr_p1, 2'b00};
        if (atk_next)
            next_level = (cur_level > atk_step) ? cur_level - atk_step : '0;
        else
            next_level = (rel_sum > {1'b0, ENV_MAX}) ? ENV_MAX : rel_sum[ENV_WIDTH-1:0];
    end

    always_ff @(posedge clk) begin
        ar_p1 <= ar;                        // align rates with stage 1
        rr_p1 <= rr;
        env_level_p2 <= next_level;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                lvl_inv_mem[i] <= '0;
                atk_mem[i] <= 1'b0;
            end
        end else if (valid_p1) begin
            lvl_inv_mem[slot_p1] <= ~next_level;    // write back at stage 2
            atk_mem[slot_p1] <= atk_next;
        end
    end

endmodule

`default_nettype wire

//--- source/fm_operator.sv
`timescale 1ns/1ps
`default_nettype none

module fm_operator
    import opl_op_pkg::*;
#(
    parameter int NUM_SLOTS = 4,
    localparam int SLOT_W = $clog2(NUM_SLOTS)
) (
    input wire clk,
    input wire rst,
    input wire slot_valid,
    input wire [SLOT_W-1:0] slot_num,
    input wire kon,
    input wire [2:0] block,
    input wire [9:0] fnum,
    input wire [1:0] mult,
    input wire ws,
    input wire [2:0] fb,
    input wire [3:0] tl,
    output logic key_on_p1,
    output logic key_off_p1,
    output logic valid_p1,
    output logic [SLOT_W-1:0] slot_p1,
    input wire [ENV_WIDTH-1:0] env_level_p2,
    output logic out_valid,
    output logic [SLOT_W-1:0] out_slot,
    output logic signed [OUT_WIDTH-1:0] out_value
);
    localparam int LUT_W = 10;              // phase bits used for the wave
    localparam logic [4:0] MAX_SHIFT = 5'd11;

    logic [16:0] fnum_sh;                   // fnum << block
    logic [PHASE_WIDTH-1:0] inc_s0;

    logic kon_p1;
    logic [PHASE_WIDTH-1:0] inc_p1;
    logic ws_p1;
    logic [2:0] fb_p1;
    logic [3:0] tl_p1;

    logic kon_mem [NUM_SLOTS];              // kon seen on previous sample
    logic [PHASE_WIDTH-1:0] phase_mem [NUM_SLOTS];
    logic signed [OUT_WIDTH-1:0] hist0_mem [NUM_SLOTS];     // newest output
    logic signed [OUT_WIDTH-1:0] hist1_mem [NUM_SLOTS];     // one before

    logic [PHASE_WIDTH-1:0] base_phase;
    logic signed [OUT_WIDTH:0] fb_sum;
    logic signed [OUT_WIDTH+7:0] fb_wide;
    logic [LUT_W-1:0] fb_mod_s1;

    logic valid_p2;
    logic [SLOT_W-1:0] slot_p2;
    logic [LUT_W-1:0] phase_top_p2;
    logic [LUT_W-1:0] fb_mod_p2;
    logic ws_p2;
    logic [3:0] tl_p2;
    logic signed [OUT_WIDTH-1:0] hist0_p2;

    logic [LUT_W-1:0] lut_idx;
    logic [7:0] tri_q;                      // position within a quarter
    logic [OUT_WIDTH-2:0] mag;
    logic signed [OUT_WIDTH-1:0] wave;
    logic [4:0] shift_sum;
    logic [3:0] shift;
    logic signed [OUT_WIDTH-1:0] out_s2;

    // stage 0: increment from the freshly decoded registers
    always_comb begin
        fnum_sh = 17'(fnum) << block;
        inc_s0 = PHASE_WIDTH'(fnum_sh) * PHASE_WIDTH'({1'b0, mult} + 3'd1);
    end

    // stage 1: memory reads and key edges
    always_comb begin
        key_on_p1 = valid_p1 & kon_p1 & ~kon_mem[slot_p1];
        key_off_p1 = valid_p1 & ~kon_p1 & kon_mem[slot_p1];
        base_phase = key_on_p1 ? '0 : phase_mem[slot_p1];   // phase restarts
        fb_sum = hist0_mem[slot_p1] + hist1_mem[slot_p1];
        fb_wide = (OUT_WIDTH+8)'(fb_sum) <<< fb_p1;
        fb_wide = fb_wide >>> 5;
        fb_mod_s1 = (fb_p1 == 3'd0) ? '0 : fb_wide[LUT_W-1:0];
    end

    // stage 2: waveform and attenuation
    always_comb begin
        lut_idx = phase_top_p2 + fb_mod_p2; // modulo wrap intended
        tri_q = lut_idx[LUT_W-2] ? ~lut_idx[7:0] : lut_idx[7:0];   // fold falling half
        if (ws_p2)
            mag = '1;                       // square, full scale
        else
            mag = {tri_q, tri_q[7:5]};      // 255 maps to 2047
        wave = lut_idx[LUT_W-1] ? -$signed({1'b0, mag}) : $signed({1'b0, mag});
        shift_sum = {1'b0, env_level_p2[ENV_WIDTH-1 -: 4]} + {1'b0, tl_p2};
        shift = (shift_sum > MAX_SHIFT) ? MAX_SHIFT[3:0] : shift_sum[3:0];
        out_s2 = wave >>> shift;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_p1 <= 1'b0;
            valid_p2 <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            valid_p1 <= slot_valid;
            valid_p2 <= valid_p1;
            out_valid <= valid_p2;          // 3 cycles after slot_valid
        end
    end

    always_ff @(posedge clk) begin
        slot_p1 <= slot_num;
        kon_p1 <= kon;
        inc_p1 <= inc_s0;
        ws_p1 <= ws;
        fb_p1 <= fb;
        tl_p1 <= tl;
        slot_p2 <= slot_p1;
        phase_top_p2 <= base_phase[PHASE_WIDTH-1 -: LUT_W];
        fb_mod_p2 <= fb_mod_s1;
        ws_p2 <= ws_p1;
        tl_p2 <= tl_p1;
        hist0_p2 <= hist0_mem[slot_p1];
        out_slot <= slot_p2;
        out_value <= out_s2;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                kon_mem[i] <= 1'b0;
                phase_mem[i] <= '0;
                hist0_mem[i] <= '0;
                hist1_mem[i] <= '0;
            end
        end else begin
            if (valid_p1) begin
                kon_mem[slot_p1] <= kon_p1;
                phase_mem[slot_p1] <= base_phase + inc_p1;
            end
            if (valid_p2) begin
                hist1_mem[slot_p2] <= hist0_p2;     // shift feedback history
                hist0_mem[slot_p2] <= out_s2;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/opl_op_core.sv
`timescale 1ns/1ps
`default_nettype none

module opl_op_core
    import opl_op_pkg::*;
#(
    parameter int NUM_SLOTS = 4,
    parameter int SAMPLE_DIV = 16,          // at least NUM_SLOTS + 4
    localparam int SLOT_W = $clog2(NUM_SLOTS)
) (
    input wire clk,
    input wire rst,
    input wire reg_we,
    input wire [SLOT_W:0] reg_addr,         // page bit on top, slot below
    input wire [REG_WIDTH-1:0] reg_wdata,
    output logic out_valid,
    output logic [SLOT_W-1:0] out_slot,
    output logic signed [OUT_WIDTH-1:0] out_value,
    output logic frame_done
);
    logic sample_tick;
    logic slot_valid;
    logic [SLOT_W-1:0] slot_num;
    logic kon;
    logic [2:0] block;
    logic [9:0] fnum;
    logic [1:0] mult;
    logic ws;
    logic [2:0] fb;
    logic [3:0] ar;
    logic [3:0] rr;
    logic [3:0] tl;
    logic key_on_p1;
    logic key_off_p1;
    logic valid_p1;
    logic [SLOT_W-1:0] slot_p1;
    logic [ENV_WIDTH-1:0] env_level_p2;

    sample_timer #(.SAMPLE_DIV(SAMPLE_DIV)) sample_timer_i (
        .clk, .rst, .sample_tick
    );

    slot_sequencer #(.NUM_SLOTS(NUM_SLOTS)) slot_sequencer_i (
        .clk, .rst, .sample_tick, .slot_valid, .slot_num, .frame_done
    );

    slot_regs #(.NUM_SLOTS(NUM_SLOTS)) slot_regs_i (
        .clk, .rst, .reg_we, .reg_addr, .reg_wdata, .slot_num,
        .kon, .block, .fnum, .mult, .ws, .fb, .ar, .rr, .tl
    );

    env_gen #(.NUM_SLOTS(NUM_SLOTS)) env_gen_i (
        .clk, .rst, .valid_p1, .slot_p1, .key_on_p1, .key_off_p1,
        .ar, .rr, .env_level_p2
    );

    fm_operator #(.NUM_SLOTS(NUM_SLOTS)) fm_operator_i (
        .clk, .rst, .slot_valid, .slot_num,
        .kon, .block, .fnum, .mult, .ws, .fb, .tl,
        .key_on_p1, .key_off_p1, .valid_p1, .slot_p1, .env_level_p2,
        .out_valid, .out_slot, .out_value
    );

endmodule

`default_nettype wire

//--- source/opl_op_pkg.sv
`default_nettype none

package opl_op_pkg;

    localparam int PHASE_WIDTH = 19;        // phase accumulator
    localparam int OUT_WIDTH = 12;          // signed operator output
    localparam int ENV_WIDTH = 7;           // attenuation, 0 loudest, 127 silent
    localparam int REG_WIDTH = 16;          // host register word

    // top bit of reg_addr picks which view a write lands in
    localparam logic PAGE_FREQ = 1'b0;
    localparam logic PAGE_ENV = 1'b1;

    // one host word, read either as a frequency page or an envelope page
    typedef union packed {
        struct packed {
            logic       kon;                // key on
            logic [2:0] block;              // octave
            logic [9:0] fnum;               // frequency number
            logic [1:0] mult;               // multiplier minus one
        } freq;
        struct packed {
            logic       ws;                 // 0 triangle, 1 square
            logic [2:0] fb;                 // self-feedback depth
            logic [3:0] ar;                 // attack rate
            logic [3:0] rr;                 // release rate
            logic [3:0] tl;                 // total level
        } env;
    } op_reg_u;

endpackage

`default_nettype wire

//--- source/sample_timer.sv
`timescale 1ns/1ps
`default_nettype none

module sample_timer #(
    parameter int SAMPLE_DIV = 16,
    localparam int CNT_W = $clog2(SAMPLE_DIV)
) (
    input wire clk,
    input wire rst,
    output logic sample_tick
);
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(SAMPLE_DIV - 1);

    logic [CNT_W-1:0] cnt;                  // cycles left until next tick

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= RELOAD;
            sample_tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt <= RELOAD;                  // wrap and fire
            sample_tick <= 1'b1;
        end else begin
            cnt <= cnt - 1'b1;
            sample_tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- source/slot_regs.sv
`timescale 1ns/1ps
`default_nettype none

module slot_regs
    import opl_op_pkg::*;
#(
    parameter int NUM_SLOTS = 4,
    localparam int SLOT_W = $clog2(NUM_SLOTS)
) (
    input wire clk,
    input wire rst,
    input wire reg_we,
    input wire [SLOT_W:0] reg_addr,
    input wire [REG_WIDTH-1:0] reg_wdata,
    input wire [SLOT_W-1:0] slot_num,
    output logic kon,
    output logic [2:0] block,
    output logic [9:0] fnum,
    output logic [1:0] mult,
    output logic ws,
    output logic [2:0] fb,
    output logic [3:0] ar,
    output logic [3:0] rr,
    output logic [3:0] tl
);
    op_reg_u freq_mem [NUM_SLOTS];          // frequency page per slot
    op_reg_u env_mem [NUM_SLOTS];           // envelope page per slot
    op_reg_u freq_rd;
    op_reg_u env_rd;

    logic [SLOT_W-1:0] wr_slot;
    logic wr_page;

    assign wr_slot = reg_addr[SLOT_W-1:0];
    assign wr_page = reg_addr[SLOT_W];      // page select is the top address bit

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                freq_mem[i] <= '0;          // keys off, fnum 0
                env_mem[i] <= '0;
            end
        end else if (reg_we) begin
            if (wr_page == PAGE_FREQ)
                freq_mem[wr_slot] <= reg_wdata;
            else if (wr_page == PAGE_ENV)
                env_mem[wr_slot] <= reg_wdata;
        end
    end

    // same-cycle decode for the slot entering the pipeline
    always_comb begin
        freq_rd = freq_mem[slot_num];
        env_rd = env_mem[slot_num];
        kon = freq_rd.freq.kon;
        block = freq_rd.freq.block;
        fnum = freq_rd.freq.fnum;
        mult = freq_rd.freq.mult;
        ws = env_rd.env.ws;
        fb = env_rd.env.fb;
        ar = env_rd.env.ar;
        rr = env_rd.env.rr;
        tl = env_rd.env.tl;
    end

endmodule

`default_nettype wire

//--- source/slot_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module slot_sequencer #(
    parameter int NUM_SLOTS = 4,
    localparam int SLOT_W = $clog2(NUM_SLOTS)
) (
    input wire clk,
    input wire rst,
    input wire sample_tick,
    output logic slot_valid,
    output logic [SLOT_W-1:0] slot_num,
    output logic frame_done
);
    localparam logic [1:0] IDLE = 2'd0;
    localparam logic [1:0] SCAN = 2'd1;
    localparam logic [1:0] DRAIN = 2'd2;

    localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(NUM_SLOTS - 1);
    localparam logic [1:0] PIPE_DEPTH = 2'd3;    // slot_valid to out_valid

    logic [1:0] state;
    logic [1:0] drain_cnt;                  // cycles until frame_done

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            slot_valid <= 1'b0;
            slot_num <= '0;
            drain_cnt <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;             // single-cycle pulse
            case (state)
                IDLE: begin
                    if (sample_tick) begin
                        state <= SCAN;
                        slot_valid <= 1'b1;
                        slot_num <= '0;     // start from slot 0
                    end
                end
                SCAN: begin
                    if (slot_num == LAST_SLOT) begin
                        state <= DRAIN;
                        slot_valid <= 1'b0;
                        drain_cnt <= PIPE_DEPTH - 2'd1;
                    end else begin
                        slot_num <= slot_num + 1'b1;
                    end
                end
                DRAIN: begin
                    if (drain_cnt == 2'd1) begin
                        frame_done <= 1'b1; // lands with last out_valid
                        state <= IDLE;
                    end else begin
                        drain_cnt <= drain_cnt - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire
